// ==== sources.f ====
+incdir+hw
hw/heat_types_pkg.sv
hw/heat_ctrl_pkg.sv
hw/heat_state_if.sv
hw/heat_device_store.sv
hw/heat_device_scheduler.sv
hw/heat_send_handler.sv
hw/heat_recv_handler.sv
hw/heat_device_top.sv
dv/heat_device_props.sv
dv/heat_device_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module heat_device_tb -f sources.f -o heat_sim
./obj_dir/heat_sim +verilator+error+limit+1000 > sim.log
cat sim.log
grep -q "^Everything OK$" sim.log

// ==== dv/heat_device_tb.sv ====
`timescale 1ns/10ps
`include "heat_cfg.svh"

module heat_device_tb;

    import heat_types_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DIRECTED_OPS = 40;
    localparam int RANDOM_OPS = 300;
    localparam int WATCHDOG_CYCLES = 8 + (DIRECTED_OPS + RANDOM_OPS) * 4 + 100;

    logic                   clk;
    logic                   reset_n;
    logic                   send_req;
    logic [`HEAT_IDX_W-1:0] send_index;
    logic                   msg_in_valid;
    heat_msg_t              msg_in;
    logic [`HEAT_IDX_W-1:0] msg_dst_index;
    temp_t                  edge_weight;
    logic                   prop_wr_valid;
    logic [`HEAT_IDX_W-1:0] prop_wr_index;
    dev_props_t             prop_wr_data;
    heat_msg_t              pkt_out;
    logic                   pkt_out_valid;

    dev_state_t  model_state [`HEAT_DEVICES];
    dev_props_t  model_props [`HEAT_DEVICES];
    heat_msg_t   last_pkt;
    logic [31:0] lcg_state = 32'hdaaa_12a0;
    int          errors = 0;

    heat_device_top UUT (.*);

    bind heat_device_top heat_device_props u_props (
        .clk           (clk),
        .reset_n       (reset_n),
        .send_req      (send_req),
        .pkt_out_valid (pkt_out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // full width product of two Q8.8 values, scaled back and cut to 16 bits.
    function automatic temp_t q88_product(input temp_t a, input temp_t b);
        logic signed [31:0] wide;
        wide = (32'(a) * 32'(b)) >>> `HEAT_FRAC;
        return wide[15:0];
    endfunction

    task automatic compare_msg(input string name, input heat_msg_t exp, input heat_msg_t act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_temp(input string name, input temp_t exp, input temp_t act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic drive_point();
        @(posedge clk);
        #5;
    endtask

    task automatic start_send(input int idx, output heat_msg_t exp);
        temp_t emit;
        emit = model_state[idx].acc_now;
        if (model_props[idx].is_dirichlet) begin
            emit = emit + model_props[idx].init_value;
        end
        exp.t = model_state[idx].t + 16'd1;
        exp.temp = emit;
        exp.source = 8'(idx);
        exp.is_designated = model_state[idx].is_designated;
        model_state[idx].t = exp.t;
        model_state[idx].heat = emit;
        model_state[idx].acc_now = q88_product(emit, model_props[idx].self_weight);
        model_state[idx].acc_next = '0;
        model_state[idx].seen_now = model_state[idx].seen_next;
        model_state[idx].seen_next = '0;
        send_req = 1'b1;
        send_index = idx[`HEAT_IDX_W-1:0];
    endtask

    task automatic start_recv(input int idx, input logic [15:0] t, input temp_t temp,
                              input temp_t w);
        temp_t prod;
        prod = q88_product(temp, w);
        if (t == model_state[idx].t) begin
            model_state[idx].acc_now = model_state[idx].acc_now + prod;
            model_state[idx].seen_now = model_state[idx].seen_now + 8'd1;
        end else begin
            model_state[idx].acc_next = model_state[idx].acc_next + prod;
            model_state[idx].seen_next = model_state[idx].seen_next + 8'd1;
        end
        msg_in_valid = 1'b1;
        msg_dst_index = idx[`HEAT_IDX_W-1:0];
        msg_in = '0;
        msg_in.t = t;
        msg_in.temp = temp;
        edge_weight = w;
    endtask

    // packets are sampled on the falling edge, half a cycle away from any change.
    task automatic wait_packet(input string name, input heat_msg_t exp);
        int waited;
        waited = 0;
        while (!pkt_out_valid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (!pkt_out_valid) begin
            errors++;
            $display("%s: no packet came out after the send request", name);
        end else begin
            last_pkt = pkt_out;
            compare_msg(name, exp, pkt_out);
        end
    endtask

    task automatic send_dev(input string name, input int idx);
        heat_msg_t exp;
        drive_point();
        start_send(idx, exp);
        drive_point();
        send_req = 1'b0;
        wait_packet(name, exp);
    endtask

    task automatic recv_dev(input int idx, input logic [15:0] t, input temp_t temp,
                            input temp_t w);
        drive_point();
        start_recv(idx, t, temp, w);
        drive_point();
        msg_in_valid = 1'b0;
    endtask

    // the model applies the receive before the send, as the scheduler does.
    task automatic send_with_recv(input string name, input int s_idx, input int r_idx,
                                  input logic [15:0] t, input temp_t temp, input temp_t w);
        heat_msg_t exp;
        drive_point();
        start_recv(r_idx, t, temp, w);
        start_send(s_idx, exp);
        drive_point();
        send_req = 1'b0;
        msg_in_valid = 1'b0;
        wait_packet(name, exp);
    endtask

    task automatic write_props(input int idx, input logic dir, input logic des,
                               input temp_t init, input temp_t w);
        drive_point();
        prop_wr_valid = 1'b1;
        prop_wr_index = idx[`HEAT_IDX_W-1:0];
        prop_wr_data = '{is_dirichlet: dir, is_designated: des, init_value: init, self_weight: w};
        model_props[idx] = prop_wr_data;
        model_state[idx].is_designated = des;
        drive_point();
        prop_wr_valid = 1'b0;
    endtask

    task automatic test_after_reset();
        heat_msg_t exp;
        exp = '0;
        exp.t = 16'd1;
        exp.source = 8'd5;
        send_dev("after_reset", 5);
        compare_msg("after_reset_fields", exp, last_pkt);
    endtask

    // init 1.5 and weight 0.5 give 1.5 first and 2.25 on the next step.
    task automatic test_dirichlet();
        write_props(1, 1'b1, 1'b0, 16'sh0180, 16'sh0080);
        send_dev("dirichlet_send1", 1);
        compare_temp("dirichlet_step1", 16'sh0180, last_pkt.temp);
        send_dev("dirichlet_send2", 1);
        compare_temp("dirichlet_step2", 16'sh0240, last_pkt.temp);
    endtask

    task automatic test_accumulate();
        recv_dev(2, model_state[2].t, 16'sh0100, 16'sh0080);
        recv_dev(2, model_state[2].t, 16'sh0200, 16'sh0040);
        send_dev("acc_now_send", 2);
        compare_temp("acc_now_temp", 16'sh0100, last_pkt.temp);
        recv_dev(2, model_state[2].t + 16'd1, 16'sh0300, 16'sh0100);
        send_dev("acc_next_send1", 2);
        compare_temp("acc_next_hidden", 16'sh0000, last_pkt.temp);
        send_dev("acc_next_send2", 2);
    endtask

    task automatic test_designated();
        write_props(3, 1'b0, 1'b1, 16'sh0000, 16'sh0100);
        recv_dev(3, model_state[3].t, 16'sh0080, 16'sh0100);
        for (int i = 0; i < 3; i++) begin
            send_dev("designated_send", 3);
            if (!last_pkt.is_designated) begin
                errors++;
                $display("packet from designated device 3 came without its flag");
            end
        end
    endtask

    task automatic test_collision();
        write_props(4, 1'b0, 1'b0, 16'sh0000, 16'sh00c0);
        send_with_recv("collide_same", 4, 4, model_state[4].t, 16'sh0100, 16'sh0100);
        compare_temp("collide_order", 16'sh0100, last_pkt.temp);
        send_with_recv("collide_other", 5, 6, model_state[6].t, 16'sh0140, 16'sh0080);
        send_dev("collide_recv_landed", 6);
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [31:0] v;
        logic [15:0] msg_t;
        int          idx;
        int          sidx;
        for (int i = 0; i < `HEAT_DEVICES; i++) begin
            r = lcg_next();
            write_props(i, r[0], r[1], temp_t'($signed(r[12:2])), temp_t'($signed(r[24:16])));
        end
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = lcg_next();
            v = lcg_next();
            idx = int'(r[7:0]) % `HEAT_DEVICES;
            sidx = int'(r[15:8]) % `HEAT_DEVICES;
            msg_t = model_state[idx].t + 16'(r[16]);
            case (r[31:29])
                3'd0, 3'd1: send_dev("random_send", idx);
                3'd2: send_with_recv("random_both", sidx, idx, msg_t,
                                     temp_t'($signed(v[10:0])), temp_t'($signed(v[24:16])));
                default: recv_dev(idx, msg_t, temp_t'($signed(v[10:0])),
                                  temp_t'($signed(v[24:16])));
            endcase
        end
    endtask

    initial begin
        int total;
        reset_n = 1'b0;
        send_req = 1'b0;
        send_index = '0;
        msg_in_valid = 1'b0;
        msg_in = '0;
        msg_dst_index = '0;
        edge_weight = '0;
        prop_wr_valid = 1'b0;
        prop_wr_index = '0;
        prop_wr_data = '0;
        last_pkt = '0;
        for (int i = 0; i < `HEAT_DEVICES; i++) begin
            model_state[i] = '0;
            model_props[i] = '0;
        end
        repeat (8) @(posedge clk);
        #5 reset_n = 1'b1;

        test_after_reset();
        test_dirichlet();
        test_accumulate();
        test_designated();
        test_collision();
        test_random();

        repeat (4) @(posedge clk);
        total = errors + UUT.u_props.assert_failures;
        $display("%0d check errors and %0d assertion failures",
                 errors, UUT.u_props.assert_failures);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== dv/heat_device_props.sv ====
`timescale 1ns/10ps

module heat_device_props (
    input logic clk,
    input logic reset_n,
    input logic send_req,
    input logic pkt_out_valid
);

    int assert_failures = 0;

    pulse_check: assert property (@(posedge clk) disable iff (!reset_n)
        pkt_out_valid |=> !pkt_out_valid)
    else begin
        $error("pkt_out_valid stayed high for more than one cycle");
        assert_failures++;
    end

    reset_quiet: assert property (@(posedge clk) !reset_n |-> !pkt_out_valid)
    else begin
        $error("pkt_out_valid was high during reset");
        assert_failures++;
    end

    // the packet shows up two cycles after the request, or three when a receive went first.
    send_latency: assert property (@(posedge clk) disable iff (!reset_n)
        send_req |-> ##[2:3] pkt_out_valid)
    else begin
        $error("no packet within three cycles of send_req");
        assert_failures++;
    end

endmodule

// ==== hw/heat_device_top.sv ====
`timescale 1ns/10ps
`include "heat_cfg.svh"

module heat_device_top (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       send_req,
    input  logic [`HEAT_IDX_W-1:0]     send_index,
    input  logic                       msg_in_valid,
    input  heat_types_pkg::heat_msg_t  msg_in,
    input  logic [`HEAT_IDX_W-1:0]     msg_dst_index,
    input  heat_types_pkg::temp_t      edge_weight,
    input  logic                       prop_wr_valid,
    input  logic [`HEAT_IDX_W-1:0]     prop_wr_index,
    input  heat_types_pkg::dev_props_t prop_wr_data,
    output heat_types_pkg::heat_msg_t  pkt_out,
    output logic                       pkt_out_valid
);

    heat_state_if st_bus ();
    heat_state_if send_bus ();
    heat_state_if recv_bus ();

    heat_device_store u_store (
        .clk           (clk),
        .reset_n       (reset_n),
        .st            (st_bus.store),
        .prop_wr_valid (prop_wr_valid),
        .prop_wr_index (prop_wr_index),
        .prop_wr_data  (prop_wr_data)
    );

    heat_device_scheduler u_sched (
        .clk        (clk),
        .reset_n    (reset_n),
        .send_req   (send_req),
        .send_index (send_index),
        .recv_req   (msg_in_valid),
        .recv_index (msg_dst_index),
        .st         (st_bus.sched)
    );

    // both handlers see the issued operation and each acts only on its own opcode.
    assign send_bus.op = st_bus.op;
    assign send_bus.index = st_bus.index;
    assign send_bus.rd_state = st_bus.rd_state;
    assign send_bus.props = st_bus.props;

    assign recv_bus.op = st_bus.op;
    assign recv_bus.index = st_bus.index;
    assign recv_bus.rd_state = st_bus.rd_state;
    assign recv_bus.props = st_bus.props;

    // at most one handler writes back in any cycle.
    assign st_bus.wr_valid = send_bus.wr_valid | recv_bus.wr_valid;
    assign st_bus.wr_state = send_bus.wr_valid ? send_bus.wr_state : recv_bus.wr_state;

    heat_send_handler u_send (
        .clk           (clk),
        .reset_n       (reset_n),
        .st            (send_bus.handler),
        .pkt_out       (pkt_out),
        .pkt_out_valid (pkt_out_valid)
    );

    heat_recv_handler u_recv (
        .clk         (clk),
        .reset_n     (reset_n),
        .st          (recv_bus.handler),
        .msg_in      (msg_in),
        .edge_weight (edge_weight)
    );

endmodule

// ==== hw/heat_recv_handler.sv ====
`timescale 1ns/10ps

module heat_recv_handler (
    input  logic                      clk,
    input  logic                      reset_n,
    heat_state_if.handler             st,
    input  heat_types_pkg::heat_msg_t msg_in,
    input  heat_types_pkg::temp_t     edge_weight
);

    import heat_types_pkg::*;
    import heat_ctrl_pkg::*;

    heat_msg_t  msg_q;
    temp_t      weight_q;
    temp_t      prod;
    dev_state_t new_state;
    logic       wr_valid;

    // the message is accepted one edge before its operation is issued.
    always_ff @(posedge clk) begin
        msg_q <= msg_in;
        weight_q <= edge_weight;
    end

    assign prod = fx_mul(msg_q.temp, weight_q);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= (st.op == OP_RECV);
        end
    end

    // a message from a neighbor that is already one step ahead counts toward the next step.
    always_ff @(posedge clk) begin
        if (st.op == OP_RECV) begin
            new_state <= st.rd_state;
            if (msg_q.t == st.rd_state.t) begin
                new_state.acc_now <= st.rd_state.acc_now + prod;
                new_state.seen_now <= st.rd_state.seen_now + 8'd1;
            end else begin
                new_state.acc_next <= st.rd_state.acc_next + prod;
                new_state.seen_next <= st.rd_state.seen_next + 8'd1;
            end
        end
    end

    assign st.wr_state = new_state;
    assign st.wr_valid = wr_valid;

endmodule

// ==== hw/heat_send_handler.sv ====
`timescale 1ns/10ps

module heat_send_handler (
    input  logic                      clk,
    input  logic                      reset_n,
    heat_state_if.handler             st,
    output heat_types_pkg::heat_msg_t pkt_out,
    output logic                      pkt_out_valid
);

    import heat_types_pkg::*;
    import heat_ctrl_pkg::*;

    temp_t      emit_temp;
    dev_state_t new_state;
    heat_msg_t  pkt;
    logic       wr_valid;

    // a Dirichlet device adds its fixed boundary value to the gathered heat.
    assign emit_temp = st.props.is_dirichlet ? st.rd_state.acc_now + st.props.init_value
                                             : st.rd_state.acc_now;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pkt_out_valid <= 1'b0;
            wr_valid <= 1'b0;
        end else begin
            pkt_out_valid <= (st.op == OP_SEND);
            wr_valid <= (st.op == OP_SEND);
        end
    end

    always_ff @(posedge clk) begin
        if (st.op == OP_SEND) begin
            new_state.t <= st.rd_state.t + 16'd1;
            new_state.heat <= emit_temp;
            new_state.acc_now <= fx_mul(emit_temp, st.props.self_weight);
            new_state.acc_next <= '0;
            new_state.seen_now <= st.rd_state.seen_next;
            new_state.seen_next <= '0;
            new_state.is_designated <= st.rd_state.is_designated;

            pkt.t <= st.rd_state.t + 16'd1;
            pkt.temp <= emit_temp;
            pkt.source <= 8'(st.index);
            pkt.is_designated <= st.rd_state.is_designated;
        end
    end

    assign st.wr_state = new_state;
    assign st.wr_valid = wr_valid;
    assign pkt_out = pkt;

endmodule

// ==== hw/heat_device_scheduler.sv ====
`timescale 1ns/10ps
`include "heat_cfg.svh"

module heat_device_scheduler (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   send_req,
    input  logic [`HEAT_IDX_W-1:0] send_index,
    input  logic                   recv_req,
    input  logic [`HEAT_IDX_W-1:0] recv_index,
    heat_state_if.sched            st
);

    import heat_ctrl_pkg::*;

    sched_state_e           state;
    logic [`HEAT_IDX_W-1:0] pend_index;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            st.op <= OP_IDLE;
            st.index <= '0;
            state <= SCHED_IDLE;
            pend_index <= '0;
        end else begin
            if (recv_req) begin
                // receives win, a colliding send waits in the pending slot.
                st.op <= OP_RECV;
                st.index <= recv_index;
                if (send_req) begin
                    state <= SCHED_BUSY;
                    pend_index <= send_index;
                end
            end else if (state == SCHED_BUSY) begin
                st.op <= OP_SEND;
                st.index <= pend_index;
                state <= send_req ? SCHED_BUSY : SCHED_IDLE;
                if (send_req) begin
                    pend_index <= send_index;
                end
            end else if (send_req) begin
                st.op <= OP_SEND;
                st.index <= send_index;
            end else begin
                st.op <= OP_IDLE;
            end
        end
    end

endmodule

// ==== hw/heat_device_store.sv ====
`timescale 1ns/10ps
`include "heat_cfg.svh"

module heat_device_store (
    input  logic                       clk,
    input  logic                       reset_n,
    heat_state_if.store                st,
    input  logic                       prop_wr_valid,
    input  logic [`HEAT_IDX_W-1:0]     prop_wr_index,
    input  heat_types_pkg::dev_props_t prop_wr_data
);

    import heat_types_pkg::*;

    dev_state_t             state_mem [`HEAT_DEVICES];
    dev_props_t             props_mem [`HEAT_DEVICES];
    logic [`HEAT_IDX_W-1:0] wr_index;

    // the handler result lands one cycle after its read, so keep the index of that read.
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_index <= '0;
            for (int i = 0; i < `HEAT_DEVICES; i++) begin
                state_mem[i] <= '0;
                props_mem[i] <= '0;
            end
        end else begin
            wr_index <= st.index;
            if (st.wr_valid) begin
                state_mem[wr_index] <= st.wr_state;
            end
            if (prop_wr_valid) begin
                props_mem[prop_wr_index] <= prop_wr_data;
                state_mem[prop_wr_index].is_designated <= prop_wr_data.is_designated;
            end
        end
    end

    // a back-to-back operation on the same device must see the write still in flight.
    always_comb begin
        st.rd_state = state_mem[st.index];
        if (st.wr_valid && (wr_index == st.index)) begin
            st.rd_state = st.wr_state;
        end
        st.props = props_mem[st.index];
    end

endmodule

// ==== hw/heat_state_if.sv ====
`timescale 1ns/10ps
`include "heat_cfg.svh"

interface heat_state_if;

    heat_ctrl_pkg::heat_op_e         op;
    logic [`HEAT_IDX_W-1:0]          index;
    heat_types_pkg::dev_state_t      rd_state;
    heat_types_pkg::dev_state_t      wr_state;
    logic                            wr_valid;
    heat_types_pkg::dev_props_t      props;

    modport sched (
        output op,
        output index
    );

    modport store (
        input  index,
        input  wr_state,
        input  wr_valid,
        output rd_state,
        output props
    );

    // the handler writes back one cycle after op, to the index that was issued with it.
    modport handler (
        input  op,
        input  index,
        input  rd_state,
        input  props,
        output wr_state,
        output wr_valid
    );

endinterface

// ==== hw/heat_ctrl_pkg.sv ====
package heat_ctrl_pkg;

    // operation issued on the state port in a given cycle.
    typedef enum logic [1:0] {
        OP_IDLE,
        OP_SEND,
        OP_RECV
    } heat_op_e;

    // busy means a send is parked behind a receive.
    typedef enum logic {
        SCHED_IDLE,
        SCHED_BUSY
    } sched_state_e;

endpackage

// ==== hw/heat_types_pkg.sv ====
`include "heat_cfg.svh"

package heat_types_pkg;

    // signed Q8.8 value, used for temperatures and for weights.
    typedef logic signed [15:0] temp_t;

    typedef struct packed {
        logic  is_dirichlet;
        logic  is_designated;
        temp_t init_value;
        temp_t self_weight;
    } dev_props_t;

    typedef struct packed {
        logic [15:0] t;
        temp_t       heat;
        temp_t       acc_now;
        temp_t       acc_next;
        logic [7:0]  seen_now;
        logic [7:0]  seen_next;
        logic        is_designated;
    } dev_state_t;

    // temperature packet sent to the neighbors of a device.
    typedef struct packed {
        logic [15:0] t;
        temp_t       temp;
        logic [7:0]  source;
        logic        is_designated;
    } heat_msg_t;

    // full width product, rescaled and cut back to 16 bits.
    function automatic temp_t fx_mul(input temp_t a, input temp_t b);
        logic signed [31:0] prod;
        logic signed [31:0] scaled;
        prod = a * b;
        scaled = prod >>> `HEAT_FRAC;
        return scaled[15:0];
    endfunction

endpackage

// ==== hw/heat_cfg.svh ====
`ifndef HEAT_CFG_SVH
`define HEAT_CFG_SVH

// number of devices held by one thread, a power of two from 2 to 64.
`define HEAT_DEVICES 8

`define HEAT_IDX_W $clog2(`HEAT_DEVICES)

// temperatures and weights are signed Q8.8.
`define HEAT_FRAC 8

`endif
